//--- src/rsa_pkg.sv
package rsa_pkg;

    // APB requester bundle
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // APB completer bundle
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // Operand regions, least significant word first
    // Each region has room for 16 words
    localparam logic [11:0] ADDR_N    = 12'h000;
    localparam logic [11:0] ADDR_BASE = 12'h040;
    localparam logic [11:0] ADDR_EXP  = 12'h080;

    // Bit 0 is start
    localparam logic [11:0] ADDR_CTRL = 12'h0C0;
    // Bit 0 busy, bit 1 sticky done
    localparam logic [11:0] ADDR_STAT = 12'h0C4;

    localparam logic [11:0] ADDR_RES  = 12'h100;

    // Exponentiation controller states
    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        PREP   = 3'd1,
        STEP   = 3'd2,
        WAIT   = 3'd3,
        FINISH = 3'd4
    } exp_state_t;

endpackage

//--- src/rsa_prep.sv
module rsa_prep #(
    parameter int WIDTH = 256
) (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_start,
    input  logic [WIDTH-1:0] i_n,
    input  logic [WIDTH-1:0] i_b,
    output logic             o_done,
    output logic [WIDTH-1:0] o_m
);

    // Iteration counter runs 0 to WIDTH inclusive
    localparam int CW = $clog2(WIDTH + 1);
    localparam logic [CW-1:0] LAST = CW'(WIDTH);

    logic             busy_q;
    logic [CW-1:0]    cnt_q;
    logic             done_q;
    logic [WIDTH-1:0] t_q;
    logic [WIDTH-1:0] m_q;

    logic [WIDTH:0]   t_dbl;
    logic [WIDTH:0]   m_sum;
    logic [WIDTH-1:0] t_next;
    logic [WIDTH-1:0] m_next;
    logic             last;

    always_comb begin
        t_dbl = {t_q, 1'b0};
        m_sum = {1'b0, m_q} + {1'b0, t_q};
        // Both terms are below N, so one subtraction is enough
        if (t_dbl >= {1'b0, i_n}) begin
            t_next = WIDTH'(t_dbl - {1'b0, i_n});
        end else begin
            t_next = t_dbl[WIDTH-1:0];
        end
        if (m_sum >= {1'b0, i_n}) begin
            m_next = WIDTH'(m_sum - {1'b0, i_n});
        end else begin
            m_next = m_sum[WIDTH-1:0];
        end
        // Only bit WIDTH of the multiplier 2^WIDTH is set
        last = (cnt_q == LAST);
    end

    always_ff @(posedge i_clk or negedge i_rst) begin
        if (!i_rst) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= busy_q && last;
            if (i_start && !busy_q) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (busy_q) begin
                cnt_q <= cnt_q + 1'b1;
                if (last) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    // Running doubled term and accumulator
    always_ff @(posedge i_clk) begin
        if (i_start && !busy_q) begin
            t_q <= i_b;
            m_q <= '0;
        end else if (busy_q) begin
            t_q <= t_next;
            if (last) begin
                m_q <= m_next;
            end
        end
    end

    assign o_done = done_q;
    assign o_m    = m_q;

endmodule

//--- src/rsa_mont.sv
module rsa_mont #(
    parameter int WIDTH = 256
) (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_start,
    input  logic [WIDTH-1:0] i_x,
    input  logic [WIDTH-1:0] i_y,
    input  logic [WIDTH-1:0] i_n,
    output logic             o_done,
    output logic [WIDTH-1:0] o_p
);

    localparam int CW = $clog2(WIDTH);
    localparam logic [CW-1:0] LAST = CW'(WIDTH - 1);

    typedef enum logic [1:0] {
        M_IDLE = 2'd0,
        M_RUN  = 2'd1,
        M_FIX  = 2'd2
    } mont_state_t;

    mont_state_t      state_q;
    logic [CW-1:0]    cnt_q;
    logic             done_q;
    logic [WIDTH-1:0] x_q;
    logic [WIDTH-1:0] y_q;
    logic [WIDTH:0]   acc_q;
    logic [WIDTH-1:0] p_q;

    logic [WIDTH+1:0] sum;
    logic [WIDTH:0]   acc_next;
    logic [WIDTH-1:0] reduced;

    always_comb begin
        // Accumulator stays below 2N, so the sum fits in WIDTH+2 bits
        sum = {1'b0, acc_q};
        if (x_q[0]) begin
            sum = sum + {2'b00, y_q};
        end
        // Make the sum even before halving
        if (sum[0]) begin
            sum = sum + {2'b00, i_n};
        end
        acc_next = sum[WIDTH+1:1];
        if (acc_q >= {1'b0, i_n}) begin
            reduced = WIDTH'(acc_q - {1'b0, i_n});
        end else begin
            reduced = acc_q[WIDTH-1:0];
        end
    end

    always_ff @(posedge i_clk or negedge i_rst) begin
        if (!i_rst) begin
            state_q <= M_IDLE;
            cnt_q   <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                M_IDLE: begin
                    if (i_start) begin
                        cnt_q   <= '0;
                        state_q <= M_RUN;
                    end
                end
                M_RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == LAST) begin
                        state_q <= M_FIX;
                    end
                end
                M_FIX: begin
                    done_q  <= 1'b1;
                    state_q <= M_IDLE;
                end
                default: state_q <= M_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_q == M_IDLE && i_start) begin
            x_q   <= i_x;
            y_q   <= i_y;
            acc_q <= '0;
        end else if (state_q == M_RUN) begin
            x_q   <= x_q >> 1;
            acc_q <= acc_next;
        end else if (state_q == M_FIX) begin
            p_q <= reduced;
        end
    end

    assign o_done = done_q;
    assign o_p    = p_q;

endmodule

//--- src/rsa_exp_ctrl.sv
module rsa_exp_ctrl #(
    parameter int WIDTH = 256
) (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_start,
    input  logic [WIDTH-1:0] i_n,
    input  logic [WIDTH-1:0] i_base,
    input  logic [WIDTH-1:0] i_exp,
    output logic             o_busy,
    output logic             o_done,
    output logic [WIDTH-1:0] o_result
);
    import rsa_pkg::*;

    localparam int IW = $clog2(WIDTH);
    localparam logic [IW-1:0]    LAST_BIT = IW'(WIDTH - 1);
    localparam logic [WIDTH-1:0] ONE      = WIDTH'(1);

    exp_state_t       state_q;
    logic [IW-1:0]    bit_q;
    logic             prep_start_q;
    logic             mont_start_q;
    logic             done_q;

    logic [WIDTH-1:0] n_q;
    logic [WIDTH-1:0] exp_q;
    // t is in Montgomery form, m stays in the normal domain
    logic [WIDTH-1:0] t_q;
    logic [WIDTH-1:0] m_q;

    logic             prep_done;
    logic [WIDTH-1:0] prep_m;
    logic             sqr_done;
    logic [WIDTH-1:0] sqr_p;
    logic             mul_done;
    logic [WIDTH-1:0] mul_p;
    logic             step_done;

    assign step_done = sqr_done && mul_done;

    always_ff @(posedge i_clk or negedge i_rst) begin
        if (!i_rst) begin
            state_q      <= IDLE;
            bit_q        <= '0;
            prep_start_q <= 1'b0;
            mont_start_q <= 1'b0;
            done_q       <= 1'b0;
        end else begin
            prep_start_q <= 1'b0;
            mont_start_q <= 1'b0;
            done_q       <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (i_start) begin
                        prep_start_q <= 1'b1;
                        state_q      <= PREP;
                    end
                end
                PREP: begin
                    if (prep_done) begin
                        bit_q   <= '0;
                        state_q <= STEP;
                    end
                end
                STEP: begin
                    mont_start_q <= 1'b1;
                    state_q      <= WAIT;
                end
                WAIT: begin
                    if (step_done) begin
                        if (bit_q == LAST_BIT) begin
                            state_q <= FINISH;
                        end else begin
                            bit_q   <= bit_q + 1'b1;
                            state_q <= STEP;
                        end
                    end
                end
                // Done rises on the same edge that drops busy
                FINISH: begin
                    done_q  <= 1'b1;
                    state_q <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_q == IDLE && i_start) begin
            n_q   <= i_n;
            exp_q <= i_exp;
        end
        if (state_q == PREP && prep_done) begin
            t_q <= prep_m;
            m_q <= ONE;
        end
        if (state_q == WAIT && step_done) begin
            t_q <= sqr_p;
            if (exp_q[bit_q]) begin
                m_q <= mul_p;
            end
        end
    end

    rsa_prep #(.WIDTH(WIDTH)) u_prep (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (prep_start_q),
        .i_n     (n_q),
        .i_b     (i_base),
        .o_done  (prep_done),
        .o_m     (prep_m)
    );

    // Squaring of t always runs alongside the multiply
    rsa_mont #(.WIDTH(WIDTH)) u_sqr (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (mont_start_q),
        .i_x     (t_q),
        .i_y     (t_q),
        .i_n     (n_q),
        .o_done  (sqr_done),
        .o_p     (sqr_p)
    );

    rsa_mont #(.WIDTH(WIDTH)) u_mul (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (mont_start_q),
        .i_x     (m_q),
        .i_y     (t_q),
        .i_n     (n_q),
        .o_done  (mul_done),
        .o_p     (mul_p)
    );

    assign o_busy   = (state_q != IDLE);
    assign o_done   = done_q;
    assign o_result = m_q;

endmodule

//--- src/rsa_apb_regs.sv
module rsa_apb_regs #(
    parameter int WIDTH = 256
) (
    input  logic              i_clk,
    input  logic              i_rst,
    input  rsa_pkg::apb_req_t i_apb,
    output rsa_pkg::apb_rsp_t o_apb,
    output logic              o_start,
    output logic [WIDTH-1:0]  o_n,
    output logic [WIDTH-1:0]  o_base,
    output logic [WIDTH-1:0]  o_exp,
    input  logic              i_busy,
    input  logic              i_done,
    input  logic [WIDTH-1:0]  i_result
);
    import rsa_pkg::*;

    localparam int WORDS = WIDTH / 32;
    localparam int WW    = (WORDS > 1) ? $clog2(WORDS) : 1;

    if ((WIDTH % 32) != 0 || WIDTH > 512) begin : g_width_check
        $error("WIDTH must be a multiple of 32 and at most 512");
    end

    logic [31:0]   n_q    [WORDS];
    logic [31:0]   base_q [WORDS];
    logic [31:0]   exp_q  [WORDS];
    logic [31:0]   res_q  [WORDS];
    logic          start_q;
    logic          done_q;

    logic          access;
    logic          busy;
    logic [3:0]    word;
    logic [WW-1:0] widx;
    logic          in_range;
    logic          sel_n;
    logic          sel_base;
    logic          sel_exp;
    logic          sel_res;
    logic          sel_ctrl;
    logic          sel_stat;
    logic          err;
    logic          wr_ok;
    logic [31:0]   rdata;

    always_comb begin
        access   = i_apb.psel && i_apb.penable;
        // Pending start counts as busy so a second start is refused
        busy     = i_busy || start_q;
        word     = i_apb.paddr[5:2];
        widx     = word[WW-1:0];
        in_range = (int'(word) < WORDS) && (i_apb.paddr[1:0] == 2'b00);
        sel_n    = in_range && (i_apb.paddr[11:6] == ADDR_N[11:6]);
        sel_base = in_range && (i_apb.paddr[11:6] == ADDR_BASE[11:6]);
        sel_exp  = in_range && (i_apb.paddr[11:6] == ADDR_EXP[11:6]);
        sel_res  = in_range && (i_apb.paddr[11:6] == ADDR_RES[11:6]);
        sel_ctrl = (i_apb.paddr == ADDR_CTRL);
        sel_stat = (i_apb.paddr == ADDR_STAT);
        err      = access && (!(sel_n || sel_base || sel_exp || sel_res || sel_ctrl || sel_stat)
                   || (i_apb.pwrite && busy && (sel_n || sel_base || sel_exp || sel_ctrl)));
        wr_ok    = access && i_apb.pwrite && !err;

        rdata = '0;
        if (sel_n) begin
            rdata = n_q[widx];
        end else if (sel_base) begin
            rdata = base_q[widx];
        end else if (sel_exp) begin
            rdata = exp_q[widx];
        end else if (sel_res) begin
            rdata = res_q[widx];
        end else if (sel_stat) begin
            rdata = {30'd0, done_q, busy};
        end
    end

    always_ff @(posedge i_clk or negedge i_rst) begin
        if (!i_rst) begin
            start_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            start_q <= wr_ok && sel_ctrl && i_apb.pwdata[0];
            // Sticky done, cleared by a new start
            if (wr_ok && sel_ctrl && i_apb.pwdata[0]) begin
                done_q <= 1'b0;
            end else if (i_done) begin
                done_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (wr_ok && sel_n) begin
            n_q[widx] <= i_apb.pwdata;
        end
        if (wr_ok && sel_base) begin
            base_q[widx] <= i_apb.pwdata;
        end
        if (wr_ok && sel_exp) begin
            exp_q[widx] <= i_apb.pwdata;
        end
        if (i_done) begin
            for (int i = 0; i < WORDS; i++) begin
                res_q[i] <= i_result[i*32 +: 32];
            end
        end
    end

    for (genvar g = 0; g < WORDS; g++) begin : g_words
        assign o_n[g*32 +: 32]    = n_q[g];
        assign o_base[g*32 +: 32] = base_q[g];
        assign o_exp[g*32 +: 32]  = exp_q[g];
    end

    assign o_start       = start_q;
    assign o_apb.prdata  = (access && !i_apb.pwrite) ? rdata : 32'd0;
    assign o_apb.pready  = 1'b1;
    assign o_apb.pslverr = err;

endmodule

//--- src/rsa_top.sv
module rsa_top #(
    parameter int WIDTH = 256
) (
    input  logic              i_clk,
    input  logic              i_rst,
    input  rsa_pkg::apb_req_t i_apb,
    output rsa_pkg::apb_rsp_t o_apb
);

    logic             start;
    logic             busy;
    logic             done;
    logic [WIDTH-1:0] op_n;
    logic [WIDTH-1:0] op_base;
    logic [WIDTH-1:0] op_exp;
    logic [WIDTH-1:0] result;

    // Software facing register block
    rsa_apb_regs #(.WIDTH(WIDTH)) u_regs (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_apb    (i_apb),
        .o_apb    (o_apb),
        .o_start  (start),
        .o_n      (op_n),
        .o_base   (op_base),
        .o_exp    (op_exp),
        .i_busy   (busy),
        .i_done   (done),
        .i_result (result)
    );

    rsa_exp_ctrl #(.WIDTH(WIDTH)) u_ctrl (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_start  (start),
        .i_n      (op_n),
        .i_base   (op_base),
        .i_exp    (op_exp),
        .o_busy   (busy),
        .o_done   (done),
        .o_result (result)
    );

endmodule

//--- dv/rsa_assertions.sv
module rsa_assertions (
    input logic                i_clk,
    input logic                i_rst,
    input rsa_pkg::apb_req_t   i_apb,
    input logic                i_busy,
    input logic                i_done,
    input logic                i_prep_done,
    input logic                i_sqr_done,
    input logic                i_mul_done,
    input rsa_pkg::exp_state_t i_state
);
    import rsa_pkg::*;

    int fail_cnt = 0;

    // Access phase only after a setup cycle
    a_setup_first: assert property (@(posedge i_clk) disable iff (!i_rst)
        $rose(i_apb.penable) |-> $past(i_apb.psel))
    else begin
        fail_cnt <= fail_cnt + 1;
        $error("penable rose without a preceding setup cycle");
    end

    a_enable_needs_sel: assert property (@(posedge i_clk) disable iff (!i_rst)
        i_apb.penable |-> i_apb.psel)
    else begin
        fail_cnt <= fail_cnt + 1;
        $error("penable high while psel low");
    end

    a_done_pulse: assert property (@(posedge i_clk) disable iff (!i_rst)
        (i_done || i_prep_done || i_sqr_done || i_mul_done)
        |=> !(i_done && $past(i_done)) && !(i_prep_done && $past(i_prep_done))
            && !(i_sqr_done && $past(i_sqr_done)) && !(i_mul_done && $past(i_mul_done)))
    else begin
        fail_cnt <= fail_cnt + 1;
        $error("a done pulse lasted more than one cycle");
    end

    // Busy drops on the same edge that raises done
    a_busy_fall: assert property (@(posedge i_clk) disable iff (!i_rst)
        $fell(i_busy) |-> i_done && $past(i_state) == FINISH)
    else begin
        fail_cnt <= fail_cnt + 1;
        $error("busy fell without the controller done pulse");
    end

endmodule

bind rsa_top rsa_assertions u_rsa_assertions (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_apb       (i_apb),
    .i_busy      (busy),
    .i_done      (done),
    .i_prep_done (u_ctrl.prep_done),
    .i_sqr_done  (u_ctrl.sqr_done),
    .i_mul_done  (u_ctrl.mul_done),
    .i_state     (u_ctrl.state_q)
);

//--- dv/rsa_tb.sv
module rsa_tb;
    import rsa_pkg::*;

    localparam int WIDTH = 32;
    localparam int NUM_RANDOM = 20;
    localparam int POLL_LIMIT = 2000;
    localparam int READY_LIMIT = 16;
    localparam logic [31:0] SEED = 32'h3085;
    localparam logic [31:0] N_FIX = 32'hD3A5_6C29;
    localparam logic [31:0] BASE_FIX = 32'h6B1F_0E37;
    localparam logic [31:0] EXP_FIX = 32'h0F0F_1235;

    logic        clk;
    logic        rst;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic [31:0] lfsr;
    int          checks = 0;
    int          errors = 0;
    int          timeouts = 0;

    // Pending comparisons filled by the stimulus and drained by the checker
    logic [31:0] want_q[$];
    logic [31:0] got_q[$];
    string       what_q[$];

    rsa_top #(.WIDTH(WIDTH)) u_rsa_top (
        .i_clk (clk),
        .i_rst (rst),
        .i_apb (apb_req),
        .o_apb (apb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    // Right-to-left square and multiply in 64-bit arithmetic
    function automatic logic [31:0] mod_exp(input logic [31:0] base, input logic [31:0] exponent,
                                            input logic [31:0] n);
        logic [63:0] n64;
        logic [63:0] r;
        logic [63:0] b;
        n64 = {32'd0, n};
        r = 64'd1 % n64;
        b = {32'd0, base} % n64;
        for (int i = 0; i < 32; i++) begin
            if (exponent[i]) begin
                r = (r * b) % n64;
            end
            b = (b * b) % n64;
        end
        return r[31:0];
    endfunction

    task automatic expect_value(input string what, input logic [31:0] want, input logic [31:0] got);
        what_q.push_back(what);
        want_q.push_back(want);
        got_q.push_back(got);
    endtask

    // One APB transfer with setup and access phases and a mid-cycle sample
    task automatic apb_xfer(input logic write, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        int waits;
        waits = 0;
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= write;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= wdata;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        while (!apb_rsp.pready && waits < READY_LIMIT) begin
            @(negedge clk);
            waits++;
        end
        if (!apb_rsp.pready) begin
            $display("Timeout: pready stayed low for %0d cycles at address %h", waits, addr);
            timeouts++;
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic load_and_start(input logic [31:0] n, input logic [31:0] base,
                                  input logic [31:0] exponent);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b1, ADDR_N, n, rdata, err);
        apb_xfer(1'b1, ADDR_BASE, base, rdata, err);
        apb_xfer(1'b1, ADDR_EXP, exponent, rdata, err);
        apb_xfer(1'b1, ADDR_CTRL, 32'd1, rdata, err);
        expect_value("start write error flag", 32'd0, {31'd0, err});
    endtask

    // Poll the sticky done bit and fetch the result
    task automatic wait_done(output logic ok, output logic [31:0] result);
        logic [31:0] stat;
        logic        err;
        int          polls;
        polls = 0;
        ok = 1'b0;
        result = '0;
        while (!ok && polls < POLL_LIMIT) begin
            apb_xfer(1'b0, ADDR_STAT, 32'd0, stat, err);
            ok = stat[1];
            polls++;
        end
        if (!ok) begin
            $display("Timeout: done bit not set after %0d status polls", polls);
            timeouts++;
        end else begin
            apb_xfer(1'b0, ADDR_RES, 32'd0, result, err);
        end
    endtask

    always @(posedge clk) begin : compare_results
        logic [31:0] want;
        logic [31:0] got;
        string       what;
        while (got_q.size() > 0) begin
            want = want_q.pop_front();
            got = got_q.pop_front();
            what = what_q.pop_front();
            checks++;
            assert (got == want) else begin
                $display("FAIL %0t: %s, expected %h, got %h", $time, what, want, got);
                errors++;
            end
        end
    end

    initial begin : stimulus
        logic [31:0] rdata;
        logic [31:0] n;
        logic [31:0] base;
        logic [31:0] exponent;
        logic        err;
        logic        ok;
        int          drain;
        int          assert_fails;
        apb_req = '0;
        rst = 1'b0;
        lfsr = SEED;
        repeat (2) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);

        apb_xfer(1'b0, ADDR_STAT, 32'd0, rdata, err);
        expect_value("status after reset", 32'd0, rdata);
        expect_value("status read error flag", 32'd0, {31'd0, err});

        // Unmapped offsets including a second N word that a 32-bit engine lacks
        apb_xfer(1'b0, 12'h200, 32'd0, rdata, err);
        expect_value("read of offset 200", 32'd1, {31'd0, err});
        apb_xfer(1'b1, ADDR_N + 12'h004, 32'hFFFF_FFFF, rdata, err);
        expect_value("write of second N word", 32'd1, {31'd0, err});
        apb_xfer(1'b0, 12'h0C8, 32'd0, rdata, err);
        expect_value("read of offset 0C8", 32'd1, {31'd0, err});

        apb_xfer(1'b1, ADDR_EXP, 32'h1357_9BDF, rdata, err);
        apb_xfer(1'b0, ADDR_EXP, 32'd0, rdata, err);
        expect_value("exponent read back", 32'h1357_9BDF, rdata);

        load_and_start(N_FIX, BASE_FIX, 32'd0);
        wait_done(ok, rdata);
        if (ok) begin
            expect_value("exponent 0", 32'd1, rdata);
        end
        load_and_start(N_FIX, BASE_FIX, 32'd1);
        wait_done(ok, rdata);
        if (ok) begin
            expect_value("exponent 1", BASE_FIX % N_FIX, rdata);
        end

        for (int k = 0; k < NUM_RANDOM; k++) begin
            draw_bits(32, n);
            n = n | 32'h8000_0001;
            draw_bits(32, base);
            base = base % n;
            draw_bits(32, exponent);
            exponent = exponent % n;
            load_and_start(n, base, exponent);
            wait_done(ok, rdata);
            if (ok) begin
                expect_value($sformatf("random job %0d", k), mod_exp(base, exponent, n), rdata);
            end
        end

        // Second start and an operand write during a running job
        load_and_start(N_FIX, BASE_FIX, EXP_FIX);
        apb_xfer(1'b0, ADDR_STAT, 32'd0, rdata, err);
        expect_value("status while busy", 32'd1, rdata);
        apb_xfer(1'b1, ADDR_CTRL, 32'd1, rdata, err);
        expect_value("start while busy error flag", 32'd1, {31'd0, err});
        apb_xfer(1'b1, ADDR_N, 32'h0000_0003, rdata, err);
        expect_value("N write while busy error flag", 32'd1, {31'd0, err});
        wait_done(ok, rdata);
        if (ok) begin
            expect_value("result after refused start", mod_exp(BASE_FIX, EXP_FIX, N_FIX), rdata);
        end
        apb_xfer(1'b0, ADDR_N, 32'd0, rdata, err);
        expect_value("N kept after refused write", N_FIX, rdata);

        drain = 0;
        while (got_q.size() > 0 && drain < 10) begin
            @(posedge clk);
            drain++;
        end
        if (got_q.size() > 0) begin
            $display("Comparison queue still held %0d entries at the end of the run",
                     got_q.size());
        end
        assert_fails = u_rsa_top.u_rsa_assertions.fail_cnt;
        $display("Summary: %0d checks, %0d mismatches, %0d timeouts, %0d assertion failures",
                 checks, errors, timeouts, assert_fails);
        if (errors == 0 && timeouts == 0 && assert_fails == 0 && got_q.size() == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- flist.f
src/rsa_pkg.sv
src/rsa_prep.sv
src/rsa_mont.sv
src/rsa_exp_ctrl.sv
src/rsa_apb_regs.sv
src/rsa_top.sv
dv/rsa_assertions.sv
dv/rsa_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the RSA engine testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module rsa_tb \
    -f flist.f \
    -o rsa_sim

# Keep running past assertion errors so the testbench prints its verdict
./obj_dir/rsa_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "All checks passed" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation did not pass"
    exit 1
fi
